//--- design/tlk2711_tx_macros.svh
// Shared constants for the TLK2711 transmit framer.
// Include where widths, code words, periods or register addresses are needed.
`ifndef TLK2711_TX_MACROS_SVH
`define TLK2711_TX_MACROS_SVH

// datapath sizes
`define TLK_WORD_W          16
`define TLK_DMA_W           64
`define TLK_LANES           4
`define TLK_LANE_DEPTH      16
`define TLK_CNT_W           7

// TLK2711 code words, upper byte first
`define TLK_IDLE_WORD       16'hC5BC
`define TLK_SOF_WORD        16'h5CFB
`define TLK_EOF_WORD        16'hFDFE
`define TLK_HEAD0           16'hEB90
`define TLK_HEAD1           16'hE116
`define TLK_FILE_SIGN       16'h8100
`define TLK_FILE_END_SIGN   16'h8101

// periods in clk cycles
`define TLK_PWR_SYNC_CYCLES 100
`define TLK_SYNC_CYCLES     6
`define TLK_GAP_CYCLES      16

// APB register map
`define TLK_ADDR_CTRL       8'h00
`define TLK_ADDR_BODY_LEN   8'h04
`define TLK_ADDR_TAIL_LEN   8'h08
`define TLK_ADDR_BODY_NUM   8'h0C
`define TLK_ADDR_INTR_W     8'h10
`define TLK_ADDR_STATUS     8'h14

`endif

//--- design/tlk2711_tx_pkg.sv
// Types shared by the framer, the register block and the assertions.
package tlk2711_tx_pkg;

    // framer states, also reported in STATUS[7:4]
    typedef enum logic [3:0] {
        PWR_SYNC  = 4'd0,
        IDLE      = 4'd1,
        SYNC      = 4'd2,
        SOF       = 4'd3,
        HEAD      = 4'd4,
        FILE_SIGN = 4'd5,
        FRAME_NUM = 4'd6,
        LENGTH    = 4'd7,
        DATA      = 4'd8,
        CHECKSUM  = 4'd9,
        EOF       = 4'd10,
        GAP       = 4'd11,
        INTERRUPT = 4'd12
    } tx_state_e;

endpackage

//--- design/tlk2711_apb_regs.sv
// APB register block for the transmit framer.
// Holds the transfer configuration, turns a CTRL write into a start pulse
// and returns framer status. No wait states.
`timescale 1ns/1ps
`include "tlk2711_tx_macros.svh"

module tlk2711_apb_regs import tlk2711_tx_pkg::*; (
    input  logic        clk,
    input  logic        i_soft_reset,
    input  logic        i_psel,
    input  logic        i_penable,
    input  logic        i_pwrite,
    input  logic [7:0]  i_paddr,
    input  logic [31:0] i_pwdata,
    input  tx_state_e   i_state,
    input  logic        i_lanes_empty,
    input  logic        i_lanes_full,
    output logic [31:0] o_prdata,
    output logic        o_pready,
    output logic        o_pslverr,
    output logic        o_start,
    output logic [15:0] o_body_len,
    output logic [15:0] o_tail_len,
    output logic [23:0] o_body_num,
    output logic [15:0] o_intr_width
);

    logic access;
    logic addr_hit;
    logic wr_en;

    assign access   = i_psel & i_penable;
    assign wr_en    = access & i_pwrite & addr_hit;
    assign o_pready = 1'b1;
    assign o_pslverr = access & ~addr_hit;

    always_comb begin
        case (i_paddr)
            `TLK_ADDR_CTRL, `TLK_ADDR_BODY_LEN, `TLK_ADDR_TAIL_LEN,
            `TLK_ADDR_BODY_NUM, `TLK_ADDR_INTR_W, `TLK_ADDR_STATUS: addr_hit = 1'b1;
            default: addr_hit = 1'b0;
        endcase
    end

    //////////////////////////////
    // register writes
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            o_start      <= 1'b0;
            o_body_len   <= '0;
            o_tail_len   <= '0;
            o_body_num   <= '0;
            o_intr_width <= '0;
        end else begin
            // one cycle wide, the cycle after the CTRL write
            o_start <= wr_en && (i_paddr == `TLK_ADDR_CTRL) && i_pwdata[0];
            if (wr_en) begin
                case (i_paddr)
                    `TLK_ADDR_BODY_LEN: o_body_len   <= i_pwdata[15:0];
                    `TLK_ADDR_TAIL_LEN: o_tail_len   <= i_pwdata[15:0];
                    `TLK_ADDR_BODY_NUM: o_body_num   <= i_pwdata[23:0];
                    `TLK_ADDR_INTR_W:   o_intr_width <= i_pwdata[15:0];
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////
    // read mux
    //////////////////////////////
    always_comb begin
        case (i_paddr)
            `TLK_ADDR_BODY_LEN: o_prdata = {16'b0, o_body_len};
            `TLK_ADDR_TAIL_LEN: o_prdata = {16'b0, o_tail_len};
            `TLK_ADDR_BODY_NUM: o_prdata = {8'b0, o_body_num};
            `TLK_ADDR_INTR_W:   o_prdata = {16'b0, o_intr_width};
            // busy, empty, full, then the state nibble
            `TLK_ADDR_STATUS:
                o_prdata = {24'b0, i_state, 1'b0, i_lanes_full, i_lanes_empty,
                            i_state != IDLE};
            default: o_prdata = '0;
        endcase
    end

endmodule

//--- design/tx_lane_fifo.sv
// One 16-bit lane FIFO, first word fall through.
// The head word is visible on o_rd_data whenever o_empty is low.
`timescale 1ns/1ps
`include "tlk2711_tx_macros.svh"

module tx_lane_fifo (
    input  logic                  clk,
    input  logic                  i_soft_reset,
    input  logic                  i_wr_en,
    input  logic [`TLK_WORD_W-1:0] i_wr_data,
    input  logic                  i_rd_en,
    output logic [`TLK_WORD_W-1:0] o_rd_data,
    output logic                  o_empty,
    output logic                  o_full,
    output logic [`TLK_CNT_W-1:0] o_count
);

    localparam int PTR_W = $clog2(`TLK_LANE_DEPTH);

    logic [`TLK_WORD_W-1:0] mem [`TLK_LANE_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic                   do_wr;
    logic                   do_rd;

    assign do_wr     = i_wr_en & ~o_full;
    assign do_rd     = i_rd_en & ~o_empty;
    assign o_empty   = (o_count == '0);
    assign o_full    = (o_count == `TLK_LANE_DEPTH);
    assign o_rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= i_wr_data;
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            o_count <= o_count + do_wr - do_rd;
        end
    end

endmodule

//--- design/tx_word_serializer.sv
// Drains the four lane FIFOs round robin into one 16-bit word stream.
// Lane 0 goes first; a pop moves the head to the next lane on the next edge.
`timescale 1ns/1ps
`include "tlk2711_tx_macros.svh"

module tx_word_serializer (
    input  logic                              clk,
    input  logic                              i_soft_reset,
    input  logic [`TLK_LANES*`TLK_WORD_W-1:0] i_lane_data,
    input  logic [`TLK_LANES-1:0]             i_lane_empty,
    input  logic [`TLK_LANES*`TLK_CNT_W-1:0]  i_lane_count,
    input  logic                              i_word_pop,
    output logic [`TLK_LANES-1:0]             o_lane_rd,
    output logic [`TLK_WORD_W-1:0]            o_word,
    output logic [`TLK_CNT_W-1:0]             o_word_count,
    output logic                              o_empty
);

    logic [1:0] lane_ptr;

    assign o_word  = i_lane_data[lane_ptr*`TLK_WORD_W +: `TLK_WORD_W];
    assign o_empty = &i_lane_empty;

    // read strobe only to the selected lane
    always_comb begin
        o_lane_rd = '0;
        if (i_word_pop && !i_lane_empty[lane_ptr])
            o_lane_rd[lane_ptr] = 1'b1;
    end

    // total words held, summed over lanes
    always_comb begin
        o_word_count = '0;
        for (int i = 0; i < `TLK_LANES; i++)
            o_word_count = o_word_count + i_lane_count[i*`TLK_CNT_W +: `TLK_CNT_W];
    end

    always_ff @(posedge clk) begin
        if (i_soft_reset)
            lane_ptr <= '0;
        else if (|o_lane_rd)
            lane_ptr <= lane_ptr + 1'b1;
    end

endmodule

//--- design/tx_frame_fsm.sv
// TLK2711 normal-mode framer.
// Sequences power-up idle, sync, frames with gaps and the end interrupt,
// pops payload words from the serializer and drives registered pins.
`timescale 1ns/1ps
`include "tlk2711_tx_macros.svh"

module tx_frame_fsm import tlk2711_tx_pkg::*; (
    input  logic                   clk,
    input  logic                   i_soft_reset,
    input  logic                   i_start,
    input  logic [15:0]            i_body_len,
    input  logic [15:0]            i_tail_len,
    input  logic [23:0]            i_body_num,
    input  logic [15:0]            i_intr_width,
    input  logic [`TLK_WORD_W-1:0] i_word,
    input  logic [`TLK_CNT_W-1:0]  i_word_count,
    output logic                   o_word_pop,
    output tx_state_e              o_state,
    output logic                   o_tx_interrupt,
    output logic [`TLK_WORD_W-1:0] o_2711_txd,
    output logic                   o_2711_tkmsb,
    output logic                   o_2711_tklsb,
    output logic                   o_2711_enable,
    output logic                   o_2711_lckrefn
);

    tx_state_e              state;
    tx_state_e              state_nxt;
    logic [15:0]            cyc_cnt;
    logic [23:0]            frame_cnt;
    logic                   last_frame;
    logic [15:0]            frame_len;
    logic [15:0]            next_len;
    logic [15:0]            checksum;
    logic                   start_flag;
    logic                   data_ok;
    logic [`TLK_WORD_W-1:0] tx_word;
    logic                   tk_msb;
    logic                   tk_lsb;

    assign o_state    = state;
    assign o_word_pop = (state == DATA);
    assign next_len   = (frame_cnt == i_body_num) ? i_tail_len : i_body_len;
    // enough words buffered for the coming frame, or lanes can hold no more
    assign data_ok = (16'(i_word_count) >= {1'b0, next_len[15:1]}) ||
                     (i_word_count == `TLK_LANES * `TLK_LANE_DEPTH);

    //////////////////////////////
    // next state
    //////////////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            PWR_SYNC:  if (cyc_cnt == `TLK_PWR_SYNC_CYCLES - 1) state_nxt = IDLE;
            IDLE:      if (start_flag && i_word_count != '0) state_nxt = SYNC;
            SYNC:      if (cyc_cnt >= `TLK_SYNC_CYCLES - 1 && data_ok) state_nxt = SOF;
            SOF:       state_nxt = HEAD;
            HEAD:      if (cyc_cnt == 16'd1) state_nxt = FILE_SIGN;
            FILE_SIGN: state_nxt = FRAME_NUM;
            FRAME_NUM: state_nxt = LENGTH;
            LENGTH:    state_nxt = (frame_len[15:1] == '0) ? CHECKSUM : DATA;
            DATA:      if (cyc_cnt == frame_len[15:1] - 1'b1) state_nxt = CHECKSUM;
            CHECKSUM:  state_nxt = EOF;
            EOF:       state_nxt = GAP;
            GAP: begin
                if (cyc_cnt >= `TLK_GAP_CYCLES - 1) begin
                    if (last_frame)
                        state_nxt = INTERRUPT;
                    else if (data_ok)
                        state_nxt = SOF;
                end
            end
            INTERRUPT: if (cyc_cnt + 1'b1 >= i_intr_width) state_nxt = IDLE;
            default:   state_nxt = IDLE;
        endcase
    end

    //////////////////////////////
    // state, counters, checksum
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            state      <= PWR_SYNC;
            cyc_cnt    <= '0;
            frame_cnt  <= '0;
            last_frame <= 1'b0;
            frame_len  <= '0;
            checksum   <= '0;
            start_flag <= 1'b0;
        end else begin
            state <= state_nxt;
            // cycles spent in the current state, saturating
            if (state_nxt != state)
                cyc_cnt <= '0;
            else if (cyc_cnt != '1)
                cyc_cnt <= cyc_cnt + 1'b1;

            if (i_start)
                start_flag <= 1'b1;
            else if (state_nxt == GAP && state != GAP)
                start_flag <= 1'b0;

            if (state == IDLE)
                frame_cnt <= '0;
            else if (state == EOF)
                frame_cnt <= frame_cnt + 1'b1;

            // frame length and tail flag latched for the whole frame
            if (state == SOF) begin
                last_frame <= (frame_cnt == i_body_num);
                frame_len  <= next_len;
                checksum   <= '0;
            end else if (state == FRAME_NUM || state == LENGTH || state == DATA) begin
                checksum <= checksum + tx_word;
            end
        end
    end

    //////////////////////////////
    // word and k-flag select
    //////////////////////////////
    always_comb begin
        tx_word = `TLK_IDLE_WORD;
        tk_msb  = 1'b0;
        tk_lsb  = 1'b0;
        case (state)
            SOF:       {tx_word, tk_msb, tk_lsb} = {`TLK_SOF_WORD, 2'b11};
            HEAD:      tx_word = cyc_cnt[0] ? `TLK_HEAD1 : `TLK_HEAD0;
            FILE_SIGN: tx_word = last_frame ? `TLK_FILE_END_SIGN : `TLK_FILE_SIGN;
            FRAME_NUM: tx_word = frame_cnt[15:0];
            LENGTH:    tx_word = frame_len;
            DATA:      tx_word = i_word;
            CHECKSUM:  tx_word = checksum;
            EOF:       {tx_word, tk_msb, tk_lsb} = {`TLK_EOF_WORD, 2'b11};
            // idle word with K28.5 in the low byte
            default:   tk_lsb = 1'b1;
        endcase
    end

    // pins, one cycle behind the state
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            o_2711_txd     <= `TLK_IDLE_WORD;
            o_2711_tkmsb   <= 1'b0;
            o_2711_tklsb   <= 1'b1;
            o_tx_interrupt <= 1'b0;
            o_2711_enable  <= 1'b0;
            o_2711_lckrefn <= 1'b0;
        end else begin
            o_2711_txd     <= tx_word;
            o_2711_tkmsb   <= tk_msb;
            o_2711_tklsb   <= tk_lsb;
            o_tx_interrupt <= (state == INTERRUPT);
            o_2711_enable  <= 1'b1;
            o_2711_lckrefn <= 1'b1;
        end
    end

endmodule

//--- design/tlk2711_tx_top.sv
// Top level of the TLK2711 transmit path.
// APB configures the transfer, DMA beats fill four lane FIFOs, and the
// framer sends them out through the serializer on the TLK2711 pins.
`timescale 1ns/1ps
`include "tlk2711_tx_macros.svh"

module tlk2711_tx_top import tlk2711_tx_pkg::*; (
    input  logic                   clk,
    input  logic                   i_soft_reset,
    input  logic                   i_psel,
    input  logic                   i_penable,
    input  logic                   i_pwrite,
    input  logic [7:0]             i_paddr,
    input  logic [31:0]            i_pwdata,
    output logic [31:0]            o_prdata,
    output logic                   o_pready,
    output logic                   o_pslverr,
    input  logic                   i_dma_rd_valid,
    input  logic [`TLK_DMA_W-1:0]  i_dma_rd_data,
    output logic                   o_dma_rd_ready,
    output logic                   o_tx_interrupt,
    output logic [`TLK_WORD_W-1:0] o_2711_txd,
    output logic                   o_2711_tkmsb,
    output logic                   o_2711_tklsb,
    output logic                   o_2711_enable,
    output logic                   o_2711_lckrefn
);

    logic                              start;
    logic [15:0]                       body_len;
    logic [15:0]                       tail_len;
    logic [23:0]                       body_num;
    logic [15:0]                       intr_width;
    tx_state_e                         state;
    logic                              dma_wr;
    logic [`TLK_LANES*`TLK_WORD_W-1:0] lane_data;
    logic [`TLK_LANES-1:0]             lane_empty;
    logic [`TLK_LANES-1:0]             lane_full;
    logic [`TLK_LANES*`TLK_CNT_W-1:0]  lane_count;
    logic [`TLK_LANES-1:0]             lane_rd;
    logic [`TLK_WORD_W-1:0]            word;
    logic [`TLK_CNT_W-1:0]             word_count;
    logic                              word_empty;
    logic                              word_pop;

    // back-pressure as soon as any lane is full
    assign o_dma_rd_ready = ~|lane_full;
    assign dma_wr         = i_dma_rd_valid & o_dma_rd_ready;

    tlk2711_apb_regs tlk2711_apb_regs_inst (
        .clk(clk), .i_soft_reset(i_soft_reset),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .i_state(state), .i_lanes_empty(word_empty), .i_lanes_full(|lane_full),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .o_start(start), .o_body_len(body_len), .o_tail_len(tail_len),
        .o_body_num(body_num), .o_intr_width(intr_width)
    );

    // lane n takes bits 16n+15:16n of each beat
    for (genvar g = 0; g < `TLK_LANES; g++) begin : g_lane
        tx_lane_fifo tx_lane_fifo_inst (
            .clk(clk), .i_soft_reset(i_soft_reset),
            .i_wr_en(dma_wr),
            .i_wr_data(i_dma_rd_data[g*`TLK_WORD_W +: `TLK_WORD_W]),
            .i_rd_en(lane_rd[g]),
            .o_rd_data(lane_data[g*`TLK_WORD_W +: `TLK_WORD_W]),
            .o_empty(lane_empty[g]), .o_full(lane_full[g]),
            .o_count(lane_count[g*`TLK_CNT_W +: `TLK_CNT_W])
        );
    end

    tx_word_serializer tx_word_serializer_inst (
        .clk(clk), .i_soft_reset(i_soft_reset),
        .i_lane_data(lane_data), .i_lane_empty(lane_empty),
        .i_lane_count(lane_count), .i_word_pop(word_pop),
        .o_lane_rd(lane_rd), .o_word(word),
        .o_word_count(word_count), .o_empty(word_empty)
    );

    tx_frame_fsm tx_frame_fsm_inst (
        .clk(clk), .i_soft_reset(i_soft_reset), .i_start(start),
        .i_body_len(body_len), .i_tail_len(tail_len),
        .i_body_num(body_num), .i_intr_width(intr_width),
        .i_word(word), .i_word_count(word_count),
        .o_word_pop(word_pop), .o_state(state), .o_tx_interrupt(o_tx_interrupt),
        .o_2711_txd(o_2711_txd), .o_2711_tkmsb(o_2711_tkmsb),
        .o_2711_tklsb(o_2711_tklsb), .o_2711_enable(o_2711_enable),
        .o_2711_lckrefn(o_2711_lckrefn)
    );

endmodule

//--- dv/tlk2711_tx_assertions.sv
// Protocol assertions for the framer, bound into tx_frame_fsm.
// Reports only through failing assertions.
`timescale 1ns/1ps
`include "tlk2711_tx_macros.svh"

module tlk2711_tx_assertions import tlk2711_tx_pkg::*; (
    input logic                   i_clk,
    input logic                   i_soft_reset,
    input tx_state_e              i_state,
    input logic                   i_last_frame,
    input logic                   i_tx_interrupt,
    input logic [`TLK_WORD_W-1:0] i_txd,
    input logic                   i_tkmsb,
    input logic                   i_tklsb,
    input logic                   i_word_pop,
    input logic [`TLK_CNT_W-1:0]  i_word_count
);

    // interrupt pin is registered and only follows the last frame
    property p_intr_in_interrupt;
        @(posedge i_clk) disable iff (i_soft_reset)
            i_tx_interrupt |-> ($past(i_state) == INTERRUPT) && $past(i_last_frame);
    endproperty

    // K pair only carries the frame delimiters
    property p_tk_pair;
        @(posedge i_clk) disable iff (i_soft_reset)
            i_tkmsb |-> i_tklsb && (i_txd == `TLK_SOF_WORD || i_txd == `TLK_EOF_WORD);
    endproperty

    // pop only in DATA and never from empty lanes
    property p_pop_in_data;
        @(posedge i_clk) disable iff (i_soft_reset)
            i_word_pop |-> (i_state == DATA) && (i_word_count != '0);
    endproperty

    a_intr_in_interrupt: assert property (p_intr_in_interrupt)
        else $error("interrupt high outside INTERRUPT state or before the last frame");
    a_tk_pair: assert property (p_tk_pair)
        else $error("tkmsb set without tklsb or on a non-delimiter word");
    a_pop_in_data: assert property (p_pop_in_data)
        else $error("word pop outside DATA state or with no words buffered");

endmodule

bind tx_frame_fsm tlk2711_tx_assertions tlk2711_tx_assertions_inst (
    .i_clk(clk),
    .i_soft_reset(i_soft_reset),
    .i_state(o_state),
    .i_last_frame(last_frame),
    .i_tx_interrupt(o_tx_interrupt),
    .i_txd(o_2711_txd),
    .i_tkmsb(o_2711_tkmsb),
    .i_tklsb(o_2711_tklsb),
    .i_word_pop(o_word_pop),
    .i_word_count(i_word_count)
);

//--- dv/tlk2711_tx_tb.sv
// Testbench for the TLK2711 transmit framer.
// Reads transfer setups from dv/tlk2711_tx_tests.txt, feeds random DMA beats
// and checks every word on the TLK2711 pins against the frame rules.
`timescale 1ns/1ps
`include "tlk2711_tx_macros.svh"

module tlk2711_tx_tb;

    logic        clk;
    logic        i_soft_reset;
    logic        i_psel;
    logic        i_penable;
    logic        i_pwrite;
    logic [7:0]  i_paddr;
    logic [31:0] i_pwdata;
    logic [31:0] o_prdata;
    logic        o_pready;
    logic        o_pslverr;
    logic        i_dma_rd_valid;
    logic [63:0] i_dma_rd_data;
    logic        o_dma_rd_ready;
    logic        o_tx_interrupt;
    logic [15:0] o_2711_txd;
    logic        o_2711_tkmsb;
    logic        o_2711_tklsb;
    logic        o_2711_enable;
    logic        o_2711_lckrefn;

    logic [31:0] tests_mem [0:159];
    logic [15:0] exp_q [$];
    integer      seed = 32'hed098bbc;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          error_count = 0;
    bit          saw_stall = 0;

    tlk2711_tx_top tlk2711_tx_top_inst (.*);

    always #50 clk = ~clk;

    //////////////////////////////
    // timeout
    //////////////////////////////
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, framer did not finish", cycles);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic bad_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        error_count++;
        stop_run($sformatf("Error at %0t: %s expected %h got %h", $time, name, exp, act));
    endtask

    //////////////////////////////
    // APB master
    //////////////////////////////
    task automatic apb_access(input logic wr, input logic [7:0] addr,
                              input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(negedge clk);
        i_psel   = 1'b1;
        i_pwrite = wr;
        i_paddr  = addr;
        i_pwdata = wdata;
        @(negedge clk);
        i_penable = 1'b1;
        #10;
        rdata = o_prdata;
        err   = o_pslverr;
        assert (o_pready) else bad_value("o_pready", 1, o_pready);
        @(negedge clk);
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic write_and_check(input logic [7:0] addr, input logic [31:0] val);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, val, rd, err);
        assert (!err) else bad_value("o_pslverr", 0, err);
        apb_access(1'b0, addr, 32'h0, rd, err);
        assert (rd == val) else bad_value("o_prdata", val, rd);
    endtask

    //////////////////////////////
    // DMA source, honors ready
    //////////////////////////////
    task automatic feed_beats(input int n_beats);
        int   left;
        logic rdy;
        left = n_beats;
        @(negedge clk);
        i_dma_rd_valid = 1'b1;
        i_dma_rd_data  = {$random(seed), $random(seed)};
        rdy = o_dma_rd_ready;
        while (left > 0) begin
            @(negedge clk);
            if (rdy) begin
                // lane 0 first
                for (int l = 0; l < 4; l++)
                    exp_q.push_back(i_dma_rd_data[l*16 +: 16]);
                left--;
                if (left > 0)
                    i_dma_rd_data = {$random(seed), $random(seed)};
                else
                    i_dma_rd_valid = 1'b0;
            end else begin
                saw_stall = 1;
            end
            rdy = o_dma_rd_ready;
        end
    endtask

    //////////////////////////////
    // pin monitor and frame checks
    //////////////////////////////
    task automatic expect_word(input logic [15:0] exp, input logic [1:0] tk, input string name);
        @(negedge clk);
        assert (o_2711_txd == exp)
            else bad_value($sformatf("o_2711_txd (%s)", name), exp, o_2711_txd);
        assert ({o_2711_tkmsb, o_2711_tklsb} == tk)
            else bad_value("{o_2711_tkmsb, o_2711_tklsb}", tk, {o_2711_tkmsb, o_2711_tklsb});
    endtask

    task automatic check_idle();
        assert (o_2711_txd == `TLK_IDLE_WORD)
            else bad_value("o_2711_txd", `TLK_IDLE_WORD, o_2711_txd);
        assert ({o_2711_tkmsb, o_2711_tklsb} == 2'b01)
            else bad_value("{o_2711_tkmsb, o_2711_tklsb}", 2'b01, {o_2711_tkmsb, o_2711_tklsb});
    endtask

    task automatic wait_sof();
        bit found;
        found = 0;
        while (!found) begin
            @(negedge clk);
            if (o_2711_tkmsb && o_2711_tklsb && o_2711_txd == `TLK_SOF_WORD)
                found = 1;
            else
                check_idle();
        end
    endtask

    task automatic check_frame(input int f, input logic [15:0] len, input bit last);
        logic [15:0] sum;
        logic [15:0] d;
        sum = 16'(f) + len;
        wait_sof();
        expect_word(`TLK_HEAD0, 2'b00, "head0");
        expect_word(`TLK_HEAD1, 2'b00, "head1");
        expect_word(last ? `TLK_FILE_END_SIGN : `TLK_FILE_SIGN, 2'b00, "file sign");
        expect_word(16'(f), 2'b00, "frame number");
        expect_word(len, 2'b00, "length");
        for (int i = 0; i < len / 2; i++) begin
            assert (exp_q.size() > 0) else stop_run("data word sent that was never accepted");
            d = exp_q.pop_front();
            sum = sum + d;
            expect_word(d, 2'b00, "data word");
        end
        expect_word(sum, 2'b00, "checksum");
        expect_word(`TLK_EOF_WORD, 2'b11, "eof");
    endtask

    task automatic check_frames(input int n_frames, input logic [15:0] body_len,
                                input logic [15:0] tail_len, input int intr_w);
        int hi;
        for (int f = 0; f < n_frames; f++)
            check_frame(f, (f == n_frames - 1) ? tail_len : body_len, f == n_frames - 1);
        @(negedge clk);
        while (!o_tx_interrupt) begin
            check_idle();
            @(negedge clk);
        end
        hi = 0;
        while (o_tx_interrupt) begin
            hi++;
            @(negedge clk);
        end
        assert (hi == intr_w) else bad_value("o_tx_interrupt width", intr_w, hi);
    endtask

    task automatic run_test(input int t);
        logic [15:0] body_len;
        logic [15:0] tail_len;
        int          body_num;
        int          intr_w;
        int          n_frames;
        int          words;
        logic [31:0] rd;
        logic        err;
        body_len = tests_mem[t*5][15:0];
        tail_len = tests_mem[t*5+1][15:0];
        body_num = tests_mem[t*5+2];
        intr_w   = tests_mem[t*5+3];
        n_frames = tests_mem[t*5+4];
        assert (n_frames == body_num + 1)
            else stop_run($sformatf("test %0d frame count does not match body number", t));
        write_and_check(`TLK_ADDR_BODY_LEN, body_len);
        write_and_check(`TLK_ADDR_TAIL_LEN, tail_len);
        write_and_check(`TLK_ADDR_BODY_NUM, body_num);
        write_and_check(`TLK_ADDR_INTR_W, intr_w);
        apb_access(1'b1, `TLK_ADDR_CTRL, 32'h1, rd, err);
        words = body_num * (body_len / 2) + tail_len / 2;
        fork
            feed_beats((words + 3) / 4);
            check_frames(n_frames, body_len, tail_len, intr_w);
        join
        apb_access(1'b0, `TLK_ADDR_STATUS, 32'h0, rd, err);
        assert (rd[0] == 1'b0) else bad_value("o_prdata busy bit", 0, rd[0]);
    endtask

    initial begin
        int          n_tests;
        int          limit;
        logic [31:0] rd;
        logic        err;
        clk = 0;
        i_soft_reset = 1;
        i_psel = 0;
        i_penable = 0;
        i_pwrite = 0;
        i_paddr = '0;
        i_pwdata = '0;
        i_dma_rd_valid = 0;
        i_dma_rd_data = '0;
        $readmemh("dv/tlk2711_tx_tests.txt", tests_mem);
        n_tests = 0;
        limit = `TLK_PWR_SYNC_CYCLES + 50;
        // a zero or unknown frame count ends the list
        while (n_tests < 32 && tests_mem[n_tests*5+4] != '0) begin
            // frame words, gaps, sync, interrupt and APB setup, with margin
            limit += 4 * ((tests_mem[n_tests*5+4]) * (8 + tests_mem[n_tests*5] / 2
                     + `TLK_GAP_CYCLES) + tests_mem[n_tests*5+1] / 2
                     + `TLK_SYNC_CYCLES + tests_mem[n_tests*5+3] + 40);
            n_tests++;
        end
        assert (n_tests > 0) else stop_run("no tests found in the test file");
        cycle_limit = limit;
        repeat (10) @(negedge clk);
        assert (!o_2711_enable) else bad_value("o_2711_enable", 0, o_2711_enable);
        assert (!o_2711_lckrefn) else bad_value("o_2711_lckrefn", 0, o_2711_lckrefn);
        assert (!o_tx_interrupt) else bad_value("o_tx_interrupt", 0, o_tx_interrupt);
        i_soft_reset = 0;
        @(negedge clk);
        assert (o_2711_enable) else bad_value("o_2711_enable", 1, o_2711_enable);
        assert (o_2711_lckrefn) else bad_value("o_2711_lckrefn", 1, o_2711_lckrefn);
        // unmapped address
        apb_access(1'b1, 8'h18, 32'h5, rd, err);
        assert (err) else bad_value("o_pslverr", 1, err);
        for (int t = 0; t < n_tests; t++)
            run_test(t);
        assert (saw_stall) else stop_run("DMA ready never dropped, back-pressure not exercised");
        assert (exp_q.size() == 0) else stop_run("accepted DMA words were never sent");
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tlk2711_tx.f
+incdir+design
design/tlk2711_tx_pkg.sv
design/tlk2711_apb_regs.sv
design/tx_lane_fifo.sv
design/tx_word_serializer.sv
design/tx_frame_fsm.sv
design/tlk2711_tx_top.sv
dv/tlk2711_tx_assertions.sv
dv/tlk2711_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the TLK2711 transmit testbench with Verilator.
# Run from the project root.

verilator --binary --timing --assert -Wno-fatal \
    --top-module tlk2711_tx_tb \
    -f tlk2711_tx.f \
    -o Vtlk2711_tx_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtlk2711_tx_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^STATUS: PASS$'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- dv/tlk2711_tx_tests.txt
// columns: body_len tail_len body_num intr_width frame_count (all hex)
// lengths in bytes, frame_count is body_num + 1
0020 0010 0003 0004 0004
0080 0040 0002 0008 0003
0018 0008 0005 0001 0006
0040 0040 0000 0002 0001
